// File: matmul_cfg.svh
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

////////////////////////////////////////////////////////////
// Data and address sizes
////////////////////////////////////////////////////////////

// One matrix element
`define MM_DWIDTH 8
// Block memory address
`define MM_AWIDTH 11
`define MM_STRIDE_WIDTH 8
// Tile is MM_SIZE x MM_SIZE PEs
`define MM_SIZE 4

////////////////////////////////////////////////////////////
// Run timing
////////////////////////////////////////////////////////////

`define MM_CNT_WIDTH 8
// Block memory answers one cycle after the address
`define MM_MEM_LATENCY 1
// Operand register, product register, accumulator
`define MM_MAC_CYCLES 3

// Count at which column 0 of C is on the outputs
`define MM_LATCH_CNT ((`MM_SIZE << 2) - `MM_SIZE - 2 + `MM_MAC_CYCLES)
// Count at which done is raised, one cycle past the last column
`define MM_DONE_CNT ((`MM_SIZE << 2) - 3 + `MM_MAC_CYCLES)

`endif

// File: matmul_pkg.sv
`include "matmul_cfg.svh"

package matmul_pkg;

  ////////////////////////////////////////////////////////////
  // Scalar widths
  ////////////////////////////////////////////////////////////

  typedef logic [`MM_DWIDTH-1:0]       mm_elem_t;
  // Full unsigned product before the narrowing
  typedef logic [2*`MM_DWIDTH-1:0]     mm_prod_t;
  typedef logic [`MM_AWIDTH-1:0]       mm_addr_t;
  typedef logic [`MM_STRIDE_WIDTH-1:0] mm_stride_t;
  typedef logic [`MM_CNT_WIDTH-1:0]    mm_cnt_t;
  // One bit per lane or per inner index
  typedef logic [`MM_SIZE-1:0]         mm_mask_t;
  // Lane 0 sits in the low byte
  typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] mm_vec_t;

  ////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////

  // One strided address stream, base first
  typedef struct packed {
    mm_addr_t   base;
    mm_stride_t stride;
  } mm_stream_t;

  // Accumulators of the array, row r lane c is C[r][c]
  typedef struct packed {
    mm_vec_t [`MM_SIZE-1:0] row;
  } mm_grid_t;

endpackage

// File: mm_sequencer.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module mm_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_start,
  output matmul_pkg::mm_cnt_t o_cnt,
  output logic                o_done
);
  import matmul_pkg::*;

  logic hit_done;

  // Last column has left the drain when the count gets here
  assign hit_done = (o_cnt == mm_cnt_t'(`MM_DONE_CNT));

  ////////////////////////////////////////////////////////////
  // Run cycle counter
  ////////////////////////////////////////////////////////////

  // Count is 0 on the first cycle with start high
  // Dropping start is the same as reset for the whole tile
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_cnt  <= '0;
      o_done <= 1'b0;
    end else begin
      // Free running while start is held, wraps only on a very long hold
      o_cnt  <= o_cnt + 1'b1;
      // Single cycle pulse, the compare is true for one count only
      o_done <= hit_done;
    end
  end

endmodule

// File: operand_feeder.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module operand_feeder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::mm_cnt_t    i_cnt,
  input  matmul_pkg::mm_stream_t i_stream,
  input  matmul_pkg::mm_vec_t    i_word,
  input  matmul_pkg::mm_mask_t   i_lane_mask,
  input  matmul_pkg::mm_mask_t   i_inner_mask,
  output matmul_pkg::mm_addr_t   o_addr,
  output matmul_pkg::mm_vec_t    o_edge
);
  import matmul_pkg::*;

  localparam int IDX_W = $clog2(`MM_SIZE);

  mm_addr_t addr_step;
  logic     mem_access;
  mm_cnt_t  access_cnt;
  mm_cnt_t  word_idx;
  logic     inner_ok;
  logic     word_valid;
  mm_vec_t  masked;
  logic     skew_clear;

  assign addr_step = mm_addr_t'(i_stream.stride);

  ////////////////////////////////////////////////////////////
  // Read address generation
  ////////////////////////////////////////////////////////////

  // Steps through base + k*stride on counts 0 to MM_SIZE-1
  // Parks at base - stride so the first step lands on base
  always_ff @(posedge clk) begin
    if (reset || !i_start || (i_cnt >= mm_cnt_t'(`MM_SIZE))) begin
      o_addr     <= i_stream.base - addr_step;
      mem_access <= 1'b0;
    end else begin
      o_addr     <= o_addr + addr_step;
      mem_access <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Returned word tracking and masking
  ////////////////////////////////////////////////////////////

  // Counts cycles of an active access burst
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      access_cnt <= '0;
    end else if (mem_access) begin
      access_cnt <= access_cnt + 1'b1;
    end else begin
      access_cnt <= '0;
    end
  end

  // Word k of the burst shows up when the counter reads k + latency
  assign word_idx   = access_cnt - mm_cnt_t'(`MM_MEM_LATENCY);
  assign inner_ok   = i_inner_mask[word_idx[IDX_W-1:0]];
  assign word_valid = (access_cnt >= mm_cnt_t'(`MM_MEM_LATENCY)) && inner_ok;

  // Zero the lanes outside the valid rows or columns
  always_comb begin
    for (int l = 0; l < `MM_SIZE; l++) begin
      masked[l*`MM_DWIDTH +: `MM_DWIDTH] = i_word[l*`MM_DWIDTH +: `MM_DWIDTH] &
                                           {`MM_DWIDTH{word_valid & i_lane_mask[l]}};
    end
  end

  ////////////////////////////////////////////////////////////
  // Diagonal skew
  ////////////////////////////////////////////////////////////

  assign skew_clear = reset || !i_start || (i_cnt == '0);

  // Lane l goes through l flops so each wavefront hits the array diagonally
  for (genvar l = 0; l < `MM_SIZE; l++) begin : g_lane
    if (l == 0) begin : g_direct
      assign o_edge[0 +: `MM_DWIDTH] = masked[0 +: `MM_DWIDTH];
    end else begin : g_delay
      mm_elem_t [l-1:0] pipe;

      always_ff @(posedge clk) begin
        if (skew_clear) begin
          pipe <= '0;
        end else begin
          pipe[0] <= masked[l*`MM_DWIDTH +: `MM_DWIDTH];
          for (int s = 1; s < l; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign o_edge[l*`MM_DWIDTH +: `MM_DWIDTH] = pipe[l-1];
    end
  end

endmodule

// File: mac_pe.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module mac_pe (
  input  logic                 clk,
  input  logic                 i_clear,
  input  matmul_pkg::mm_elem_t i_a,
  input  matmul_pkg::mm_elem_t i_b,
  output matmul_pkg::mm_elem_t o_a,
  output matmul_pkg::mm_elem_t o_b,
  output matmul_pkg::mm_elem_t o_acc
);
  import matmul_pkg::*;

  mm_prod_t prod_q;
  mm_elem_t narrow;
  logic     prod_neg;
  logic     prod_ovf;

  ////////////////////////////////////////////////////////////
  // Stage 1, operand register
  ////////////////////////////////////////////////////////////

  // Same flops feed the neighbours and the multiplier
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, product register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= mm_prod_t'(o_a) * mm_prod_t'(o_b);
    end
  end

  // Top bit acts as the sign, bits 14..7 flag an overflow
  assign prod_neg = prod_q[2*`MM_DWIDTH-1];
  assign prod_ovf = |prod_q[2*`MM_DWIDTH-2:`MM_DWIDTH-1];

  // Saturating down-cast to one element
  always_comb begin
    case ({prod_neg, prod_ovf})
      2'b00:   narrow = {1'b0, prod_q[`MM_DWIDTH-2:0]};
      2'b01:   narrow = {1'b0, {(`MM_DWIDTH-1){1'b1}}};
      2'b11:   narrow = {1'b1, prod_q[`MM_DWIDTH-2:0]};
      default: narrow = {1'b1, {(`MM_DWIDTH-1){1'b0}}};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Stage 3, accumulator
  ////////////////////////////////////////////////////////////

  // Wraps modulo 2^DWIDTH
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_acc <= '0;
    end else begin
      o_acc <= o_acc + narrow;
    end
  end

endmodule

// File: pe_array.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module pe_array (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_start,
  input  matmul_pkg::mm_vec_t  i_a_edge,
  input  matmul_pkg::mm_vec_t  i_b_edge,
  output matmul_pkg::mm_grid_t o_grid
);
  import matmul_pkg::*;

  logic     clear;
  // Forwarded operands, A moves right and B moves down
  mm_elem_t a_fwd [`MM_SIZE][`MM_SIZE];
  mm_elem_t b_fwd [`MM_SIZE][`MM_SIZE];
  mm_elem_t acc   [`MM_SIZE][`MM_SIZE];

  // Start low wipes every PE as well as reset
  assign clear = reset || !i_start;

  ////////////////////////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      mm_elem_t a_in;
      mm_elem_t b_in;

      // Left column takes A lane r from the feeder
      if (c == 0) begin : g_a_edge
        assign a_in = i_a_edge[r*`MM_DWIDTH +: `MM_DWIDTH];
      end else begin : g_a_link
        assign a_in = a_fwd[r][c-1];
      end

      // Top row takes B lane c from the feeder
      if (r == 0) begin : g_b_edge
        assign b_in = i_b_edge[c*`MM_DWIDTH +: `MM_DWIDTH];
      end else begin : g_b_link
        assign b_in = b_fwd[r-1][c];
      end

      mac_pe u_pe (
        .clk     (clk),
        .i_clear (clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_fwd[r][c]),
        .o_b     (b_fwd[r][c]),
        .o_acc   (acc[r][c])
      );
    end
  end

  // Pack accumulators, row r lane c
  always_comb begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      for (int c = 0; c < `MM_SIZE; c++) begin
        o_grid.row[r][c*`MM_DWIDTH +: `MM_DWIDTH] = acc[r][c];
      end
    end
  end

endmodule

// File: result_drain.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module result_drain (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::mm_cnt_t    i_cnt,
  input  logic                   i_done,
  input  matmul_pkg::mm_stream_t i_stream_c,
  input  matmul_pkg::mm_grid_t   i_grid,
  output matmul_pkg::mm_vec_t    o_c_data,
  output matmul_pkg::mm_addr_t   o_c_addr,
  output logic                   o_c_valid
);
  import matmul_pkg::*;

  localparam int COL_W = $clog2(`MM_SIZE);

  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_SHIFT,
    DRAIN_WAIT
  } drain_state_t;

  drain_state_t     state_q;
  logic [COL_W-1:0] col_q;
  logic             latch_en;
  mm_vec_t          col_word;
  mm_addr_t         addr_step;

  // Loaded a cycle early so column 0 is out while cnt == MM_LATCH_CNT
  assign latch_en  = (i_cnt == mm_cnt_t'(`MM_LATCH_CNT - 1));
  assign addr_step = mm_addr_t'(i_stream_c.stride);

  // Column col_q of C, lane i holds row i
  always_comb begin
    for (int i = 0; i < `MM_SIZE; i++) begin
      col_word[i*`MM_DWIDTH +: `MM_DWIDTH] = i_grid.row[i][col_q*`MM_DWIDTH +: `MM_DWIDTH];
    end
  end

  ////////////////////////////////////////////////////////////
  // Column shift-out FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start || i_done) begin
      state_q   <= DRAIN_IDLE;
      col_q     <= '0;
      o_c_valid <= 1'b0;
      o_c_data  <= '0;
      o_c_addr  <= i_stream_c.base - addr_step;
    end else begin
      case (state_q)
        DRAIN_IDLE: begin
          if (latch_en) begin
            state_q   <= DRAIN_SHIFT;
            col_q     <= col_q + 1'b1;
            o_c_valid <= 1'b1;
            o_c_data  <= col_word;
            o_c_addr  <= o_c_addr + addr_step;
          end
        end
        DRAIN_SHIFT: begin
          // One column per cycle, valid stays high
          col_q    <= col_q + 1'b1;
          o_c_data <= col_word;
          o_c_addr <= o_c_addr + addr_step;
          if (col_q == COL_W'(`MM_SIZE - 1)) begin
            state_q <= DRAIN_WAIT;
          end
        end
        default: begin
          // All columns out, hold zero until done
          o_c_valid <= 1'b0;
          o_c_data  <= '0;
        end
      endcase
    end
  end

endmodule

// File: matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::mm_stream_t i_stream_a,
  input  matmul_pkg::mm_stream_t i_stream_b,
  input  matmul_pkg::mm_stream_t i_stream_c,
  input  matmul_pkg::mm_vec_t    i_a_data,
  input  matmul_pkg::mm_vec_t    i_b_data,
  input  matmul_pkg::mm_mask_t   i_mask_a_rows,
  input  matmul_pkg::mm_mask_t   i_mask_inner,
  input  matmul_pkg::mm_mask_t   i_mask_b_cols,
  output matmul_pkg::mm_addr_t   o_a_addr,
  output matmul_pkg::mm_addr_t   o_b_addr,
  output matmul_pkg::mm_vec_t    o_c_data,
  output matmul_pkg::mm_addr_t   o_c_addr,
  output logic                   o_c_valid,
  output logic                   o_done
);
  import matmul_pkg::*;

  mm_cnt_t  cnt;
  logic     done;
  // Skewed operand edges entering the array
  mm_vec_t  a_edge;
  mm_vec_t  b_edge;
  mm_grid_t grid;

  assign o_done = done;

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  mm_sequencer u_seq (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .o_cnt   (cnt),
    .o_done  (done)
  );

  ////////////////////////////////////////////////////////////
  // Operand fetch, A by rows and B by columns
  ////////////////////////////////////////////////////////////

  operand_feeder u_feed_a (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .i_cnt        (cnt),
    .i_stream     (i_stream_a),
    .i_word       (i_a_data),
    .i_lane_mask  (i_mask_a_rows),
    .i_inner_mask (i_mask_inner),
    .o_addr       (o_a_addr),
    .o_edge       (a_edge)
  );

  operand_feeder u_feed_b (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .i_cnt        (cnt),
    .i_stream     (i_stream_b),
    .i_word       (i_b_data),
    .i_lane_mask  (i_mask_b_cols),
    .i_inner_mask (i_mask_inner),
    .o_addr       (o_b_addr),
    .o_edge       (b_edge)
  );

  ////////////////////////////////////////////////////////////
  // Compute and drain
  ////////////////////////////////////////////////////////////

  pe_array u_array (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .i_a_edge (a_edge),
    .i_b_edge (b_edge),
    .o_grid   (grid)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_cnt      (cnt),
    .i_done     (done),
    .i_stream_c (i_stream_c),
    .i_grid     (grid),
    .o_c_data   (o_c_data),
    .o_c_addr   (o_c_addr),
    .o_c_valid  (o_c_valid)
  );

endmodule

// File: tb_matmul.sv
`timescale 1ns/1ps
`include "matmul_cfg.svh"

module tb_matmul;
  import matmul_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int SEED        = 32'he0e9;
  // Cycles allowed from start to done
  localparam int RUN_TIMEOUT = 64;
  localparam int IDLE_CYCLES = 2;
  localparam int MEM_WORDS   = 1 << `MM_AWIDTH;
  localparam int N           = `MM_SIZE;

  // DUT side
  logic       clk;
  logic       reset;
  logic       start;
  mm_stream_t stream_a;
  mm_stream_t stream_b;
  mm_stream_t stream_c;
  mm_mask_t   mask_rows;
  mm_mask_t   mask_inner;
  mm_mask_t   mask_cols;
  mm_vec_t    a_data = '0;
  mm_vec_t    b_data = '0;
  mm_addr_t   a_addr;
  mm_addr_t   b_addr;
  mm_vec_t    c_data;
  mm_addr_t   c_addr;
  logic       c_valid;
  logic       done;

  // Current test vector
  string      test_name;
  mm_stream_t cfg_a;
  mm_stream_t cfg_b;
  mm_stream_t cfg_c;
  mm_mask_t   cfg_rows;
  mm_mask_t   cfg_inner;
  mm_mask_t   cfg_cols;
  mm_elem_t   mat_a [N][N];
  mm_elem_t   mat_b [N][N];
  mm_elem_t   exp_c [N][N];
  int         fd;
  int         seed;
  int         num_tests;

  // Block memory models
  mm_vec_t    mem_a [MEM_WORDS];
  mm_vec_t    mem_b [MEM_WORDS];

  matmul_top DUT (
    .clk           (clk),
    .reset         (reset),
    .i_start       (start),
    .i_stream_a    (stream_a),
    .i_stream_b    (stream_b),
    .i_stream_c    (stream_c),
    .i_a_data      (a_data),
    .i_b_data      (b_data),
    .i_mask_a_rows (mask_rows),
    .i_mask_inner  (mask_inner),
    .i_mask_b_cols (mask_cols),
    .o_a_addr      (a_addr),
    .o_b_addr      (b_addr),
    .o_c_data      (c_data),
    .o_c_addr      (c_addr),
    .o_c_valid     (c_valid),
    .o_done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Word comes back one cycle after its address
  always @(posedge clk) begin
    a_data <= mem_a[a_addr];
    b_data <= mem_b[b_addr];
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Address k of a stream, k = -1 gives the parked value
  function automatic mm_addr_t stream_addr(mm_stream_t s, int k);
    return mm_addr_t'(int'(s.base) + k * int'(s.stride));
  endfunction

  // 16 bit product down to one element, bit 15 kept as sign
  function automatic mm_elem_t narrow_product(mm_prod_t p);
    logic big;
    big = (p[14:7] != 8'd0);
    if (!p[15]) begin
      return big ? 8'h7f : {1'b0, p[6:0]};
    end
    return big ? {1'b1, p[6:0]} : 8'h80;
  endfunction

  // Lane i holds C[i][j]
  function automatic mm_vec_t column_word(int j);
    mm_vec_t w;
    for (int i = 0; i < N; i++) begin
      w[i*`MM_DWIDTH +: `MM_DWIDTH] = exp_c[i][j];
    end
    return w;
  endfunction

  task automatic compute_expected();
    mm_elem_t acc;
    mm_elem_t ea;
    mm_elem_t eb;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        acc = '0;
        for (int k = 0; k < N; k++) begin
          ea  = (cfg_rows[i] && cfg_inner[k]) ? mat_a[i][k] : '0;
          eb  = (cfg_cols[j] && cfg_inner[k]) ? mat_b[k][j] : '0;
          // Sum wraps at 8 bits
          acc = acc + narrow_product(mm_prod_t'(ea) * mm_prod_t'(eb));
        end
        exp_c[i][j] = acc;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else
      report_fail($sformatf("FAILED %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
  endtask

  // Quiet outputs, addresses parked one stride below base
  task automatic check_idle();
    assert (done === 1'b0) else
      report_fail($sformatf("%s: o_done is high while the tile is idle", test_name));
    assert (c_valid === 1'b0) else
      report_fail($sformatf("%s: o_c_valid is high while the tile is idle", test_name));
    check_value("idle C data", '0, c_data);
    check_value("idle A address", 32'(stream_addr(cfg_a, -1)), 32'(a_addr));
    check_value("idle B address", 32'(stream_addr(cfg_b, -1)), 32'(b_addr));
    check_value("idle C address", 32'(stream_addr(cfg_c, -1)), 32'(c_addr));
  endtask

  ////////////////////////////////////////////////////////////
  // Test file and memory setup
  ////////////////////////////////////////////////////////////

  task automatic read_test(output bit got);
    string tok;
    string rest;
    int    code;
    int    val;
    int    f [10];
    bit    searching;
    got       = 1'b0;
    searching = 1'b1;
    // Skip comment lines up to the next test name
    while (searching) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        searching = 1'b0;
      end else if (tok.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        test_name = tok;
        searching = 1'b0;
        got       = 1'b1;
      end
    end
    if (got) begin
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %d",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
      assert (code == 10) else
        report_fail($sformatf("Test %s has a malformed parameter line", test_name));
      cfg_a     = '{base: mm_addr_t'(f[0]), stride: mm_stride_t'(f[1])};
      cfg_b     = '{base: mm_addr_t'(f[2]), stride: mm_stride_t'(f[3])};
      cfg_c     = '{base: mm_addr_t'(f[4]), stride: mm_stride_t'(f[5])};
      cfg_rows  = mm_mask_t'(f[6]);
      cfg_inner = mm_mask_t'(f[7]);
      cfg_cols  = mm_mask_t'(f[8]);
      if (f[9] != 0) begin
        // Random operands, expected C worked out here
        for (int i = 0; i < N; i++) begin
          for (int k = 0; k < N; k++) begin
            mat_a[i][k] = mm_elem_t'($random(seed));
            mat_b[i][k] = mm_elem_t'($random(seed));
          end
        end
        compute_expected();
      end else begin
        // A, B, then expected C, each row by row
        for (int n = 0; n < 3*N*N; n++) begin
          code = $fscanf(fd, "%h", val);
          assert (code == 1) else
            report_fail($sformatf("Test %s has too few matrix values", test_name));
          if (n < N*N) begin
            mat_a[(n / N) % N][n % N] = mm_elem_t'(val);
          end else if (n < 2*N*N) begin
            mat_b[(n / N) % N][n % N] = mm_elem_t'(val);
          end else begin
            exp_c[(n / N) % N][n % N] = mm_elem_t'(val);
          end
        end
      end
    end
  endtask

  // Column k of A and row k of B at their strided addresses
  task automatic load_memories();
    mm_addr_t wa;
    mm_addr_t wb;
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem_a[w] = {mm_addr_t'(w), 10'h2a5, mm_addr_t'(w)};
      mem_b[w] = ~{mm_addr_t'(w), 10'h15a, mm_addr_t'(w)};
    end
    for (int k = 0; k < N; k++) begin
      wa = stream_addr(cfg_a, k);
      wb = stream_addr(cfg_b, k);
      for (int l = 0; l < N; l++) begin
        mem_a[wa][l*`MM_DWIDTH +: `MM_DWIDTH] = mat_a[l][k];
        mem_b[wb][l*`MM_DWIDTH +: `MM_DWIDTH] = mat_b[k][l];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One run of the tile
  ////////////////////////////////////////////////////////////

  task automatic run_test();
    int cyc;
    int na;
    int nb;
    int nc;
    bit prev_valid;
    bit got_done;
    load_memories();
    @(posedge clk);
    stream_a   <= cfg_a;
    stream_b   <= cfg_b;
    stream_c   <= cfg_c;
    mask_rows  <= cfg_rows;
    mask_inner <= cfg_inner;
    mask_cols  <= cfg_cols;
    // Let the parked addresses follow the new bases
    repeat (IDLE_CYCLES) @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    start <= 1'b1;
    cyc        = 0;
    na         = 0;
    nb         = 0;
    nc         = 0;
    prev_valid = 1'b0;
    got_done   = 1'b0;
    while (!got_done && cyc < RUN_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      // Any address off the park value is the next read
      if (a_addr != stream_addr(cfg_a, -1)) begin
        check_value($sformatf("A address %0d", na), 32'(stream_addr(cfg_a, na)), 32'(a_addr));
        na++;
      end
      if (b_addr != stream_addr(cfg_b, -1)) begin
        check_value($sformatf("B address %0d", nb), 32'(stream_addr(cfg_b, nb)), 32'(b_addr));
        nb++;
      end
      if (c_valid) begin
        assert (nc < N && (nc == 0 || prev_valid)) else
          report_fail($sformatf("%s: o_c_valid is not one run of four cycles", test_name));
        check_value($sformatf("C column %0d", nc), column_word(nc), c_data);
        check_value($sformatf("C address %0d", nc), 32'(stream_addr(cfg_c, nc)), 32'(c_addr));
        nc++;
      end
      if (done) begin
        assert (nc == N && prev_valid && !c_valid) else
          report_fail($sformatf("%s: o_done did not follow the last column", test_name));
        got_done = 1'b1;
      end
      prev_valid = c_valid;
    end
    assert (got_done) else
      report_fail($sformatf("%s: no o_done within %0d cycles", test_name, cyc));
    check_value("A address count", N, na);
    check_value("B address count", N, nb);
    // Done lasts one cycle even with start held
    @(negedge clk);
    assert (!done && !c_valid) else
      report_fail($sformatf("%s: o_done or o_c_valid stayed high after done", test_name));
    @(posedge clk);
    start <= 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk);
    @(negedge clk);
    check_idle();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bit got;
    seed       = SEED;
    num_tests  = 0;
    test_name  = "reset";
    cfg_a      = '0;
    cfg_b      = '0;
    cfg_c      = '0;
    reset      <= 1'b1;
    start      <= 1'b0;
    stream_a   <= '0;
    stream_b   <= '0;
    stream_c   <= '0;
    mask_rows  <= '0;
    mask_inner <= '0;
    mask_cols  <= '0;
    fd = $fopen("matmul_tests.txt", "r");
    assert (fd != 0) else report_fail("Could not open matmul_tests.txt for reading");
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle();
    got = 1'b1;
    while (got) begin
      read_test(got);
      if (got) begin
        run_test();
        num_tests++;
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      report_fail("No test was found in matmul_tests.txt");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: matmul_tests.txt
# name base_a stride_a base_b stride_b base_c stride_c mask_rows mask_inner mask_cols random
# unless random is 1, then A, B and expected C as 16 hex bytes each, row by row
small_all     010 04 100 10 200 01 f f f 0
01 02 00 01 00 01 01 00 02 00 01 01 01 01 01 01
01 00 02 00 00 01 00 01 01 01 00 00 00 02 01 01
01 04 03 03 01 02 00 01 03 03 05 01 02 04 03 02

saturate_wrap 7f0 08 3f8 03 7fe 01 f f f 0
ff ff 00 00 ab 10 00 00 10 00 ff 0b 00 00 00 05
ff c0 01 00 fe 10 00 02 00 00 ff 03 0c 01 00 7f
03 3f 7f 7f 54 ff 7f 20 fe 8a 91 fe 3c 05 00 7f

masked        020 01 030 02 400 04 b d 7 0
01 02 00 01 00 01 01 00 02 00 01 01 01 01 01 01
01 00 02 00 00 01 00 01 01 01 00 00 00 02 01 01
01 02 03 00 01 01 00 00 00 00 00 00 02 03 03 00

random_full   123 05 456 07 600 10 f f f 1
random_masked 050 ff 0a0 20 7c0 11 6 5 9 1

// File: sources.f
+incdir+.
matmul_pkg.sv
mm_sequencer.sv
operand_feeder.sv
mac_pe.sv
pe_array.sv
result_drain.sv
matmul_top.sv
tb_matmul.sv

// File: run_sim.sh
#!/bin/sh
# Build the matmul testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul -f sources.f -o tb_matmul_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_matmul_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides pass or fail
if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi
echo "Simulation finished cleanly"
exit 0
